//--- Makefile
TOP := tb_mem_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

//--- project.f
src/axi_pkg.sv
src/cpu_mem_pkg.sv
src/axi_master.sv
src/axi_arbiter.sv
src/axi_sram_slave.sv
src/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- src/axi_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module axi_arbiter import axi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t m0_req_i,
    input  axi_req_t m1_req_i,
    output axi_rsp_t m0_rsp_o,
    output axi_rsp_t m1_rsp_o,
    output axi_req_t s_req_o,
    input  axi_rsp_t s_rsp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE    = 2'h0,
        ARB_BUSY_RD = 2'h1,
        ARB_BUSY_WR = 2'h2
    } arb_state_e;

    arb_state_e state_q;
    arb_state_e state_d;

    logic owner_q;
    logic last_q;
    logic gnt;
    logic m0_want;
    logic m1_want;
    logic ar_hs;
    logic aw_hs;
    logic r_end;
    logic b_end;

    assign m0_want = m0_req_i.arvalid | m0_req_i.awvalid;
    assign m1_want = m1_req_i.arvalid | m1_req_i.awvalid;

    // Grant is combinational in idle so the first handshake costs no cycle
    always_comb begin
        if (state_q == ARB_IDLE) begin
            if (m0_want && m1_want) begin
                gnt = ~last_q;
            end else begin
                gnt = m1_want;
            end
        end else begin
            gnt = owner_q;
        end
    end

    assign s_req_o = gnt ? m1_req_i : m0_req_i;

    // Loser sees an all-zero response
    always_comb begin
        m0_rsp_o = '0;
        m1_rsp_o = '0;
        if (gnt) begin
            m1_rsp_o = s_rsp_i;
        end else begin
            m0_rsp_o = s_rsp_i;
        end
    end

    assign ar_hs = s_req_o.arvalid & s_rsp_i.arready;
    assign aw_hs = s_req_o.awvalid & s_rsp_i.awready;
    assign r_end = s_req_o.rready & s_rsp_i.rvalid & s_rsp_i.rlast;
    assign b_end = s_req_o.bready & s_rsp_i.bvalid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE : begin
                if (ar_hs) begin
                    state_d = ARB_BUSY_RD;
                end else if (aw_hs) begin
                    state_d = ARB_BUSY_WR;
                end
            end
            ARB_BUSY_RD : state_d = r_end ? ARB_IDLE : ARB_BUSY_RD;
            ARB_BUSY_WR : state_d = b_end ? ARB_IDLE : ARB_BUSY_WR;
            default     : state_d = ARB_IDLE;
        endcase
    end

    // last_q starts at 1 so the instruction port wins first
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ARB_IDLE;
            owner_q <= 1'b0;
            last_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && (ar_hs || aw_hs)) begin
                owner_q <= gnt;
            end
            if (state_q != ARB_IDLE && state_d == ARB_IDLE) begin
                last_q <= owner_q;
            end
        end
    end

    // The owner starts nothing new until its transaction ends
    busy_no_new_addr: assert property (
        @(posedge clk) disable iff (!rst)
        (state_q != ARB_IDLE) |-> !(s_req_o.arvalid || s_req_o.awvalid)
    );

    m0_rsp_only_owner: assert property (
        @(posedge clk) disable iff (!rst)
        (m0_rsp_o.rvalid || m0_rsp_o.bvalid) |-> (state_q != ARB_IDLE && !owner_q)
    );

    m1_rsp_only_owner: assert property (
        @(posedge clk) disable iff (!rst)
        (m1_rsp_o.rvalid || m1_rsp_o.bvalid) |-> (state_q != ARB_IDLE && owner_q)
    );

endmodule

`default_nettype wire

//--- src/axi_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_master import axi_pkg::*, cpu_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    creq_i,
    output axi_req_t    axi_req_o,
    input  axi_rsp_t    axi_rsp_i,
    output logic [31:0] rdata_o,
    output logic        wait_o
);

    typedef enum logic [2:0] {
        IDLE  = 3'h0,
        AR_CH = 3'h1,
        R_CH  = 3'h2,
        AW_CH = 3'h3,
        W_CH  = 3'h4,
        B_CH  = 3'h5
    } master_state_e;

    master_state_e state_q;
    master_state_e state_d;

    logic        arhns;
    logic        rhns;
    logic        awhns;
    logic        whns;
    logic        bhns;
    logic        rdfin;
    logic        req_rd;
    logic        req_wr;
    logic [3:0]  wstrb;
    logic [31:0] rdata_q;

    assign arhns = axi_req_o.arvalid & axi_rsp_i.arready;
    assign rhns  = axi_req_o.rready  & axi_rsp_i.rvalid;
    assign awhns = axi_req_o.awvalid & axi_rsp_i.awready;
    assign whns  = axi_req_o.wvalid  & axi_rsp_i.wready;
    assign bhns  = axi_req_o.bready  & axi_rsp_i.bvalid;
    assign rdfin = rhns & axi_rsp_i.rlast;

    // A control read always wins over a write strobe
    assign req_rd = (creq_i.req & ~creq_i.write) | creq_i.sctrl_rd;
    assign req_wr = creq_i.req & creq_i.write & ~creq_i.sctrl_rd;

    // Low bytes only
    always_comb begin
        case (creq_i.size)
            SZ_BYTE : wstrb = 4'b0001;
            SZ_HALF : wstrb = 4'b0011;
            default : wstrb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rhns) begin
            rdata_q <= axi_rsp_i.rdata;
        end
    end

    assign rdata_o = rhns ? axi_rsp_i.rdata : rdata_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE : begin
                if (req_rd) begin
                    state_d = arhns ? R_CH : AR_CH;
                end else if (req_wr) begin
                    state_d = awhns ? W_CH : AW_CH;
                end
            end
            AR_CH   : state_d = arhns ? R_CH : AR_CH;
            R_CH    : state_d = rdfin ? IDLE : R_CH;
            AW_CH   : state_d = awhns ? W_CH : AW_CH;
            W_CH    : state_d = whns ? B_CH : W_CH;
            B_CH    : state_d = bhns ? IDLE : B_CH;
            default : state_d = IDLE;
        endcase
    end

    // Address and data come straight from the held cache strobes
    always_comb begin
        axi_req_o         = '0;
        axi_req_o.araddr  = creq_i.addr;
        axi_req_o.arlen   = creq_i.sctrl_rd ? AXI_LEN_ONE : AXI_LEN_FOUR;
        axi_req_o.arburst = AXI_BURST_INCR;
        axi_req_o.awaddr  = creq_i.addr;
        axi_req_o.awlen   = AXI_LEN_ONE;
        axi_req_o.awburst = AXI_BURST_FIXED;
        axi_req_o.wdata   = creq_i.wdata;
        axi_req_o.wstrb   = wstrb;
        axi_req_o.wlast   = 1'b1;
        case (state_q)
            IDLE : begin
                axi_req_o.arvalid = req_rd;
                axi_req_o.awvalid = req_wr;
            end
            AR_CH   : axi_req_o.arvalid = 1'b1;
            R_CH    : axi_req_o.rready  = 1'b1;
            AW_CH   : axi_req_o.awvalid = 1'b1;
            W_CH    : axi_req_o.wvalid  = 1'b1;
            B_CH    : axi_req_o.bready  = 1'b1;
            default : axi_req_o.arvalid = 1'b0;
        endcase
    end

    // One low cycle per read beat and one at the write response
    always_comb begin
        case (state_q)
            IDLE    : wait_o = req_rd | req_wr;
            R_CH    : wait_o = ~rhns;
            B_CH    : wait_o = ~bhns;
            default : wait_o = 1'b1;
        endcase
    end

    // A pending address keeps its fields until it is taken
    ar_held_until_ready: assert property (
        @(posedge clk) disable iff (!rst)
        (axi_req_o.arvalid && !axi_rsp_i.arready) |=>
            (axi_req_o.arvalid && $stable(axi_req_o.araddr) && $stable(axi_req_o.arlen))
    );

    rsp_only_when_ready: assert property (
        @(posedge clk) disable iff (!rst)
        (!axi_rsp_i.rvalid || axi_req_o.rready) && (!axi_rsp_i.bvalid || axi_req_o.bready)
    );

endmodule

`default_nettype wire

//--- src/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // Burst types used on this bus, WRAP is never issued
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01
    } axi_burst_e;

    // AXI length field is beats minus one
    localparam logic [7:0] AXI_LEN_ONE  = 8'd0;
    localparam logic [7:0] AXI_LEN_FOUR = 8'd3;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Master side of all five channels
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic [7:0]  arlen;
        axi_burst_e  arburst;
        logic        awvalid;
        logic [31:0] awaddr;
        logic [7:0]  awlen;
        axi_burst_e  awburst;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wlast;
        logic        rready;
        logic        bready;
    } axi_req_t;

    // Slave side, no IDs
    typedef struct packed {
        logic        arready;
        logic        awready;
        logic        wready;
        logic        rvalid;
        logic [31:0] rdata;
        logic        rlast;
        logic        bvalid;
        logic [1:0]  bresp;
    } axi_rsp_t;

endpackage

`default_nettype wire

//--- src/axi_sram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram_slave import axi_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t s_req_i,
    output axi_rsp_t s_rsp_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        SLV_IDLE  = 2'h0,
        SLV_READ  = 2'h1,
        SLV_WRITE = 2'h2
    } slv_state_e;

    slv_state_e state_q;

    logic [31:0]      mem [MEM_WORDS];
    logic [31:0]      addr_q;
    logic [7:0]       cnt_q;
    axi_burst_e       burst_q;
    logic             bvalid_q;
    logic [IDX_W-1:0] idx;
    logic             ar_hs;
    logic             aw_hs;
    logic             r_hs;
    logic             w_hs;
    logic             b_hs;

    // Byte address to word slot, wraps at the memory depth
    assign idx = IDX_W'(addr_q[31:2] % MEM_WORDS);

    assign ar_hs = s_req_i.arvalid & s_rsp_o.arready;
    assign aw_hs = s_req_i.awvalid & s_rsp_o.awready;
    assign r_hs  = s_rsp_o.rvalid  & s_req_i.rready;
    assign w_hs  = s_req_i.wvalid  & s_rsp_o.wready;
    assign b_hs  = s_rsp_o.bvalid  & s_req_i.bready;

    always_comb begin
        s_rsp_o         = '0;
        s_rsp_o.arready = (state_q == SLV_IDLE);
        s_rsp_o.awready = (state_q == SLV_IDLE);
        s_rsp_o.wready  = (state_q == SLV_WRITE) & ~bvalid_q;
        s_rsp_o.rvalid  = (state_q == SLV_READ);
        s_rsp_o.rdata   = mem[idx];
        s_rsp_o.rlast   = (state_q == SLV_READ) && (cnt_q == 8'd0);
        s_rsp_o.bvalid  = bvalid_q;
        s_rsp_o.bresp   = AXI_RESP_OKAY;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= SLV_IDLE;
            addr_q   <= '0;
            cnt_q    <= '0;
            burst_q  <= AXI_BURST_FIXED;
            bvalid_q <= 1'b0;
        end else begin
            case (state_q)
                SLV_IDLE : begin
                    if (ar_hs) begin
                        state_q <= SLV_READ;
                        addr_q  <= s_req_i.araddr;
                        cnt_q   <= s_req_i.arlen;
                        burst_q <= s_req_i.arburst;
                    end else if (aw_hs) begin
                        state_q <= SLV_WRITE;
                        addr_q  <= s_req_i.awaddr;
                    end
                end
                SLV_READ : begin
                    // Beat is held while rready is low
                    if (r_hs) begin
                        if (cnt_q == 8'd0) begin
                            state_q <= SLV_IDLE;
                        end else begin
                            cnt_q <= cnt_q - 8'd1;
                            if (burst_q == AXI_BURST_INCR) begin
                                addr_q <= addr_q + 32'd4;
                            end
                        end
                    end
                end
                SLV_WRITE : begin
                    if (w_hs) begin
                        bvalid_q <= 1'b1;
                    end
                    if (b_hs) begin
                        bvalid_q <= 1'b0;
                        state_q  <= SLV_IDLE;
                    end
                end
                default : state_q <= SLV_IDLE;
            endcase
        end
    end

    // Strobed merge into the addressed word
    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (s_req_i.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= s_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    arlen_supported: assert property (
        @(posedge clk) disable iff (!rst)
        s_req_i.arvalid |-> (s_req_i.arlen == AXI_LEN_ONE || s_req_i.arlen == AXI_LEN_FOUR)
    );

    aw_single_fixed: assert property (
        @(posedge clk) disable iff (!rst)
        s_req_i.awvalid |-> (s_req_i.awburst == AXI_BURST_FIXED &&
                             s_req_i.awlen == AXI_LEN_ONE)
    );

endmodule

`default_nettype wire

//--- src/cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

    // Access size of a cache write, unlisted codes act as word
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } mem_size_e;

    // Cache strobes, held until wait drops
    typedef struct packed {
        logic        req;
        logic        write;
        logic        sctrl_rd;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- src/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import axi_pkg::*, cpu_mem_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    ireq_i,
    input  mem_req_t    dreq_i,
    output logic [31:0] irdata_o,
    output logic [31:0] drdata_o,
    output logic        iwait_o,
    output logic        dwait_o
);

    axi_req_t i_axi_req;
    axi_rsp_t i_axi_rsp;
    axi_req_t d_axi_req;
    axi_rsp_t d_axi_rsp;
    axi_req_t s_axi_req;
    axi_rsp_t s_axi_rsp;

    // Instruction port
    axi_master u_imaster (
        .clk       (clk),
        .rst       (rst),
        .creq_i    (ireq_i),
        .axi_req_o (i_axi_req),
        .axi_rsp_i (i_axi_rsp),
        .rdata_o   (irdata_o),
        .wait_o    (iwait_o)
    );

    // Data port
    axi_master u_dmaster (
        .clk       (clk),
        .rst       (rst),
        .creq_i    (dreq_i),
        .axi_req_o (d_axi_req),
        .axi_rsp_i (d_axi_rsp),
        .rdata_o   (drdata_o),
        .wait_o    (dwait_o)
    );

    // Master 0 is the instruction port
    axi_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .m0_req_i (i_axi_req),
        .m1_req_i (d_axi_req),
        .m0_rsp_o (i_axi_rsp),
        .m1_rsp_o (d_axi_rsp),
        .s_req_o  (s_axi_req),
        .s_rsp_i  (s_axi_rsp)
    );

    axi_sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk     (clk),
        .rst     (rst),
        .s_req_i (s_axi_req),
        .s_rsp_o (s_axi_rsp)
    );

endmodule

`default_nettype wire

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys import cpu_mem_pkg::*; ();

    localparam int MEM_WORDS  = 64;
    localparam int HALF       = MEM_WORDS / 2;
    localparam int N_RAND     = 150;
    // init, word, sub-word, line, contention, random
    localparam int N_OPS      = MEM_WORDS + 16 + 16 + 8 + 17 + 2 * N_RAND;
    localparam int MAX_CYCLES = 20 * N_OPS + 200;

    logic        clk = 1'b0;
    logic        rst;
    mem_req_t    ireq;
    mem_req_t    dreq;
    logic [31:0] irdata;
    logic [31:0] drdata;
    logic        iwait;
    logic        dwait;

    logic [31:0] model [MEM_WORDS];
    logic [31:0] rng_i;
    logic [31:0] rng_d;
    int          cycle_cnt = 0;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    int          test_fail;
    int          last_srv;

    mem_subsys_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_subsys_top (
        .clk      (clk),
        .rst      (rst),
        .ireq_i   (ireq),
        .dreq_i   (dreq),
        .irdata_o (irdata),
        .drdata_o (drdata),
        .iwait_o  (iwait),
        .dwait_o  (dwait)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Separate streams so the two ports stay reproducible when run in parallel
    function automatic logic [31:0] next_rand(input int port);
        if (port == 0) begin
            rng_i = xorshift32(rng_i);
            return rng_i;
        end
        rng_d = xorshift32(rng_d);
        return rng_d;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input mem_size_e sz);
        case (sz)
            SZ_BYTE : return {old[31:8], wd[7:0]};
            SZ_HALF : return {old[31:16], wd[15:0]};
            default : return wd;
        endcase
    endfunction

    function automatic logic port_wait(input int port);
        return (port == 0) ? iwait : dwait;
    endfunction

    function automatic logic [31:0] port_rdata(input int port);
        return (port == 0) ? irdata : drdata;
    endfunction

    task automatic drive_port(input int port, input mem_req_t r);
        if (port == 0) begin
            ireq = r;
        end else begin
            dreq = r;
        end
    endtask

    task automatic release_port(input int port);
        @(negedge clk);
        drive_port(port, '0);
    endtask

    // Holds the request until wait_o falls once per expected beat
    task automatic run_op(input int port, input logic wr, input logic sctrl,
                          input mem_size_e size, input int idx,
                          input logic [31:0] wdata, output int done_at);
        mem_req_t    r;
        logic [31:0] beats [4];
        logic [31:0] exp;
        int          nbeats;
        int          got;
        int          slot;
        int          k;
        r          = '0;
        r.req      = 1'b1;
        r.write    = wr;
        r.sctrl_rd = sctrl;
        r.size     = size;
        r.addr     = 32'(idx) << 2;
        r.wdata    = wdata;
        nbeats     = (wr || sctrl) ? 1 : 4;
        got        = 0;
        @(negedge clk);
        drive_port(port, r);
        while (got < nbeats) begin
            #1;
            if (!port_wait(port)) begin
                beats[got] = port_rdata(port);
                got++;
            end
            if (got < nbeats) begin
                @(negedge clk);
            end
        end
        done_at  = cycle_cnt;
        last_srv = port;
        if (wr) begin
            model[idx % MEM_WORDS] = merge(model[idx % MEM_WORDS], wdata, size);
        end else begin
            for (k = 0; k < nbeats; k++) begin
                slot = (idx + k) % MEM_WORDS;
                exp  = model[slot];
                chk_cnt++;
                if (beats[k] !== exp) begin
                    err_cnt++;
                    $display("[ERROR] %0t %s beat %0d word %0d: got %h, expected %h", $time,
                             (port == 0) ? "irdata_o" : "drdata_o", k, slot, beats[k], exp);
                end
            end
        end
    endtask

    task automatic single_op(input int port, input logic wr, input logic sctrl,
                             input mem_size_e size, input int idx, input logic [31:0] wdata);
        int t;
        run_op(port, wr, sctrl, size, idx, wdata, t);
        release_port(port);
    endtask

    task automatic check_waits_low();
        chk_cnt += 2;
        if (iwait !== 1'b0) begin
            err_cnt++;
            $display("[ERROR] %0t iwait_o: got %b, expected 0", $time, iwait);
        end
        if (dwait !== 1'b0) begin
            err_cnt++;
            $display("[ERROR] %0t dwait_o: got %b, expected 0", $time, dwait);
        end
    endtask

    task automatic random_ops(input int port);
        logic [31:0] rv;
        logic        wr;
        logic        sctrl;
        int          idx;
        int          gap;
        int          n;
        int          t;
        for (n = 0; n < N_RAND; n++) begin
            rv    = next_rand(port);
            wr    = (port == 1) && (rv[1:0] == 2'd0);
            sctrl = !wr && rv[2];
            // Instruction reads stay in the lower half, data writes in the upper
            if (port == 0) begin
                idx = int'(rv[31:8] % (HALF - 3));
            end else if (wr) begin
                idx = HALF + int'(rv[31:8] % HALF);
            end else begin
                idx = int'(rv[31:8] % MEM_WORDS);
            end
            run_op(port, wr, sctrl, mem_size_e'(rv[4:3]), idx, next_rand(port), t);
            gap = int'(rv[6:5]);
            if (gap > 0) begin
                release_port(port);
                repeat (gap - 1) @(negedge clk);
            end
        end
        release_port(port);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            test_fail++;
            $display("%s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int e0;
        int idx;
        int r;
        int first;
        int t_i;
        int t_d;
        rst       = 1'b0;
        ireq      = '0;
        dreq      = '0;
        rng_i     = 32'h113a_01ec;
        rng_d     = ~32'h113a_01ec;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;

        e0 = err_cnt;
        repeat (8) begin
            #1;
            check_waits_low();
            @(negedge clk);
        end
        rst = 1'b1;
        repeat (4) begin
            #1;
            check_waits_low();
            @(negedge clk);
        end
        end_test("reset state", e0);

        e0 = err_cnt;
        for (idx = 0; idx < MEM_WORDS; idx++) begin
            single_op(1, 1'b1, 1'b0, SZ_WORD, idx, next_rand(1));
        end
        end_test("memory init", e0);

        e0 = err_cnt;
        for (idx = 0; idx < 8; idx++) begin
            single_op(1, 1'b1, 1'b0, SZ_WORD, idx, next_rand(1));
        end
        for (idx = 0; idx < 8; idx++) begin
            single_op(1, 1'b0, 1'b1, SZ_WORD, idx, '0);
        end
        end_test("word write and read", e0);

        e0 = err_cnt;
        for (idx = 8; idx < 16; idx++) begin
            single_op(1, 1'b1, 1'b0, (idx % 2 == 1) ? SZ_HALF : SZ_BYTE, idx, next_rand(1));
        end
        for (idx = 8; idx < 16; idx++) begin
            single_op(1, 1'b0, 1'b1, SZ_WORD, idx, '0);
        end
        end_test("byte and half strobes", e0);

        e0 = err_cnt;
        for (r = 0; r < 8; r++) begin
            single_op(0, 1'b0, 1'b0, SZ_WORD, int'(next_rand(0) % MEM_WORDS), '0);
        end
        end_test("line fill", e0);

        // Fresh reset so the first round shows the instruction port priority
        e0  = err_cnt;
        rst = 1'b0;
        repeat (8) @(negedge clk);
        rst      = 1'b1;
        last_srv = 1;
        for (r = 0; r < 6; r++) begin
            if (r > 0) begin
                single_op((r % 2 == 1) ? 0 : 1, 1'b0, 1'b1, SZ_WORD,
                          int'(next_rand(0) % HALF), '0);
            end
            first = (last_srv == 0) ? 1 : 0;
            fork
                begin
                    run_op(0, 1'b0, 1'b0, SZ_WORD, int'(next_rand(0) % (HALF - 3)), '0, t_i);
                    release_port(0);
                end
                begin
                    run_op(1, r % 2 == 0, r % 2 == 1, SZ_WORD,
                           HALF + int'(next_rand(1) % HALF), next_rand(1), t_d);
                    release_port(1);
                end
            join
            chk_cnt++;
            if ((first == 0 && t_i >= t_d) || (first == 1 && t_d >= t_i)) begin
                err_cnt++;
                $display("Contention round %0d: port %0d did not finish first", r, first);
            end
        end
        end_test("contention", e0);

        e0 = err_cnt;
        fork
            random_ops(0);
            random_ops(1);
        join
        end_test("random mix", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
